// File: ifu_lite.f
+incdir+include
hdl/ifu_ctrl_pkg.sv
hdl/ifu_bus_pkg.sv
hdl/ifu_pc_select.sv
hdl/ifu_fetch_unit.sv
hdl/ifu_id_pipe.sv
hdl/ifu_pc_check.sv
hdl/ifu_top.sv
sim/ifu_mem_model.sv
sim/ifu_tb.sv

// File: Bender.yml
package:
  name: ifu_lite

export_include_dirs:
  - include

sources:
  - files:
      - hdl/ifu_ctrl_pkg.sv
      - hdl/ifu_bus_pkg.sv
      - hdl/ifu_pc_select.sv
      - hdl/ifu_fetch_unit.sv
      - hdl/ifu_id_pipe.sv
      - hdl/ifu_pc_check.sv
      - hdl/ifu_top.sv
  - target: simulation
    files:
      - sim/ifu_mem_model.sv
      - sim/ifu_tb.sv

// File: sim/ifu_tb.sv
// testbench for the instruction fetch stage
// applies a table of redirects, streams words under random decode stalls
// and checks every word that enters decode

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_tb;
  import ifu_ctrl_pkg::*;
  import ifu_bus_pkg::*;

  localparam int          NUM_ROWS    = 8;
  localparam int          ROW_TIMEOUT = 3000;
  localparam int          REQ_TIMEOUT = 50;
  localparam logic [31:0] BOOT_BASE   = 32'h0000_2F00;
  localparam logic [31:0] DATA_MASK   = 32'h5A5A_0000;

  // one redirect and the stream that follows it
  typedef struct packed {
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [5:0]  exc_cause;
    logic [31:0] target;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [7:0]  ready_pct;
    logic [7:0]  count;
  } row_t;

  logic clk_i, rst_ni, req, id_in_ready, valid_clear;
  logic [31:0] boot_addr, jump_target, instr_addr, instr_rdata, pc_if;
  pc_ctrl_t pc_ctrl;
  csr_pc_t csr;
  logic instr_req, instr_gnt, instr_rvalid, instr_err;
  if_id_t if_id;
  logic instr_valid_id, instr_new_id, csr_mtvec_init, pc_mismatch_alert, if_busy;

  row_t        rows [NUM_ROWS];
  integer      seed = 32'ha791;
  int          error_count, timeout_count, got_words;
  logic [31:0] exp_pc, prev_pc, prev_pc_if;
  logic        prev_valid, prev_clear, check_squash;
  logic [7:0]  cur_pct;

  ifu_top DUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr),
    .req_i               (req),
    .pc_ctrl_i           (pc_ctrl),
    .jump_target_i       (jump_target),
    .csr_i               (csr),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (valid_clear),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_err_i         (instr_err),
    .if_id_o             (if_id),
    .instr_valid_id_o    (instr_valid_id),
    .instr_new_id_o      (instr_new_id),
    .pc_if_o             (pc_if),
    .csr_mtvec_init_o    (csr_mtvec_init),
    .pc_mismatch_alert_o (pc_mismatch_alert),
    .if_busy_o           (if_busy)
  );

  ifu_mem_model u_mem (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .instr_err_o    (instr_err)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // reference rules
  ////////////////////

  // first fetch address of a redirect
  function automatic logic [31:0] expected_pc(input row_t r);
    logic [31:0] pc;
    case (r.pc_mux)
      PC_BOOT: pc = {BOOT_BASE[31:8], `IFU_BOOT_OFFSET};
      PC_JUMP: pc = r.target;
      PC_EXC: begin
        case (r.exc_pc_mux)
          EXC_PC_EXC: pc = r.mtvec & 32'hFFFF_FF00;
          // vectored irq adds one word per cause
          EXC_PC_IRQ: pc = (r.mtvec & 32'hFFFF_FF00) + 32'(r.exc_cause[4:0]) * 4;
          EXC_PC_DBD: pc = `IFU_DM_HALT_ADDR;
          default:    pc = `IFU_DM_EXC_ADDR;
        endcase
      end
      PC_ERET: pc = r.mepc;
      default: pc = r.depc;
    endcase
    return pc & ~32'h3;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= 32'h0000_3000) && (addr <= 32'h0000_30FF);
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_table();
    // pc_mux, exc_pc_mux, cause, target, mtvec, mepc, depc, ready percent, words
    rows[0] = '{PC_BOOT, EXC_PC_EXC, 6'h00, BOOT_BASE, 32'h0, 32'h0, 32'h0, 8'd100, 8'd40};
    rows[1] = '{PC_JUMP, EXC_PC_EXC, 6'h00, 32'h1000, 32'h0, 32'h0, 32'h0, 8'd60, 8'd24};
    rows[2] = '{PC_EXC, EXC_PC_EXC, 6'h02, 32'h0, 32'h4001, 32'h0, 32'h0, 8'd80, 8'd12};
    rows[3] = '{PC_EXC, EXC_PC_IRQ, 6'h27, 32'h0, 32'h4001, 32'h0, 32'h0, 8'd50, 8'd16};
    rows[4] = '{PC_EXC, EXC_PC_DBD, 6'h00, 32'h0, 32'h4001, 32'h0, 32'h0, 8'd70, 8'd8};
    rows[5] = '{PC_EXC, EXC_PC_DBG_EXC, 6'h00, 32'h0, 32'h4001, 32'h0, 32'h0, 8'd40, 8'd8};
    rows[6] = '{PC_ERET, EXC_PC_EXC, 6'h00, 32'h0, 32'h0, 32'h5008, 32'h0, 8'd30, 8'd12};
    // return stream runs out of the error window
    rows[7] = '{PC_DRET, EXC_PC_EXC, 6'h00, 32'h0, 32'h0, 32'h0, 32'h30F0, 8'd90, 8'd10};
  endtask

  ////////////////////
  // per cycle monitor and drive
  ////////////////////

  task automatic tick();
    @(posedge clk_i);
    #1;
    compare_word("pc_mismatch_alert_o", 32'(pc_mismatch_alert), 32'h0);
    if (check_squash) begin
      compare_word("instr_valid_id_o after squash", 32'(instr_valid_id), 32'h0);
      check_squash = 1'b0;
    end
    // decode word stays until cleared
    if (prev_valid && !prev_clear) begin
      compare_word("held instr_valid_id_o", 32'(instr_valid_id), 32'h1);
      compare_word("held if_id_o.pc", if_id.pc, prev_pc);
    end
    if (instr_new_id && instr_valid_id) begin
      compare_word("if_id_o.pc", if_id.pc, exp_pc);
      // fetch buffer pc seen in the accept cycle
      compare_word("pc_if_o", prev_pc_if, exp_pc);
      compare_word("if_id_o.instr_rdata", if_id.instr_rdata, exp_pc ^ DATA_MASK);
      compare_word("if_id_o.fetch_err", 32'(if_id.fetch_err), 32'(in_err_window(exp_pc)));
      exp_pc = exp_pc + `IFU_INSTR_STEP;
      got_words++;
    end
    prev_valid = instr_valid_id;
    prev_pc    = if_id.pc;
    prev_pc_if = pc_if;
    // decode takes the next word in the same cycle it retires the current one
    id_in_ready    = ($unsigned($random(seed)) % 100) < cur_pct;
    valid_clear    = id_in_ready;
    prev_clear     = valid_clear;
    pc_ctrl.pc_set = 1'b0;
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   waited;
    r = rows[idx];
    // stall decode until the next word of the running stream arrives
    if (idx > 0) begin
      cur_pct = 8'd0;
      waited  = 0;
      while (!instr_rvalid && waited < REQ_TIMEOUT) begin
        tick();
        waited++;
      end
      if (!instr_rvalid) begin
        $display("Timeout: no instruction response before the redirect of row %0d", idx);
        timeout_count++;
      end
    end
    tick();
    csr         = '{mepc: r.mepc, depc: r.depc, mtvec: r.mtvec};
    jump_target = r.target;
    cur_pct     = r.ready_pct;
    // redirect with decode ready so a buffered word is accepted and squashed
    pc_ctrl      = '{pc_set: 1'b1, pc_mux: r.pc_mux, exc_pc_mux: r.exc_pc_mux,
                     exc_cause: r.exc_cause};
    id_in_ready  = 1'b1;
    valid_clear  = 1'b1;
    prev_clear   = 1'b1;
    exp_pc       = expected_pc(r);
    got_words    = 0;
    check_squash = 1'b1;
    #1;
    compare_word("csr_mtvec_init_o", 32'(csr_mtvec_init), 32'(r.pc_mux == PC_BOOT));
    waited = 0;
    if (r.pc_mux == PC_BOOT) begin
      tick();
      while (!instr_req && waited < REQ_TIMEOUT) begin
        tick();
        waited++;
      end
      if (!instr_req) begin
        $display("Timeout: no instruction request after the boot redirect");
        timeout_count++;
      end
      compare_word("first instr_addr_o", instr_addr, exp_pc);
    end
    waited = 0;
    while (got_words < r.count && waited < ROW_TIMEOUT) begin
      tick();
      waited++;
    end
    if (got_words < r.count) begin
      $display("Timeout: row %0d got %0d of %0d words", idx, got_words, r.count);
      timeout_count++;
    end
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req           = 1'b0;
    boot_addr     = BOOT_BASE;
    pc_ctrl       = '0;
    jump_target   = '0;
    csr           = '0;
    id_in_ready   = 1'b0;
    valid_clear   = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    got_words     = 0;
    exp_pc        = '0;
    prev_pc       = '0;
    prev_pc_if    = '0;
    prev_valid    = 1'b0;
    prev_clear    = 1'b0;
    check_squash  = 1'b0;
    cur_pct       = 8'd100;
    load_table();
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    req    = 1'b1;
    // nothing moves before the boot redirect
    repeat (4) begin
      tick();
      compare_word("if_busy_o", 32'(if_busy), 32'h0);
      compare_word("instr_req_o", 32'(instr_req), 32'h0);
      compare_word("instr_valid_id_o", 32'(instr_valid_id), 32'h0);
      compare_word("instr_new_id_o", 32'(instr_new_id), 32'h0);
      compare_word("csr_mtvec_init_o", 32'(csr_mtvec_init), 32'h0);
    end
    for (int i = 0; i < NUM_ROWS && timeout_count == 0; i++) begin
      run_row(i);
    end
    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim/ifu_mem_model.sv
// instruction memory model for the fetch stage testbench
// random grant and response delays, data is the address xor a mask

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_req_i,
  input  logic [`IFU_ADDR_W-1:0] instr_addr_i,
  output logic                   instr_gnt_o,
  output logic                   instr_rvalid_o,
  output logic [`IFU_ADDR_W-1:0] instr_rdata_o,
  output logic                   instr_err_o
);

  localparam logic [`IFU_ADDR_W-1:0] DATA_MASK = 32'h5A5A_0000;
  localparam logic [`IFU_ADDR_W-1:0] ERR_LO    = 32'h0000_3000;
  localparam logic [`IFU_ADDR_W-1:0] ERR_HI    = 32'h0000_30FF;

  typedef enum logic [1:0] {
    IDLE,
    GRANT,
    RESPOND
  } state_e;

  state_e                 state_q;
  logic [1:0]             delay_q;
  logic [`IFU_ADDR_W-1:0] addr_q;
  integer                 seed = 32'ha791;

  // grant and rvalid are single cycle pulses
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      delay_q        <= '0;
      addr_q         <= '0;
      instr_gnt_o    <= 1'b0;
      instr_rvalid_o <= 1'b0;
      instr_rdata_o  <= '0;
      instr_err_o    <= 1'b0;
    end else begin
      instr_gnt_o    <= 1'b0;
      instr_rvalid_o <= 1'b0;
      case (state_q)
        // pick the grant delay, 0 to 3 extra cycles
        IDLE: begin
          if (instr_req_i) begin
            delay_q <= 2'($unsigned($random(seed)) % 4);
            state_q <= GRANT;
          end
        end
        // grant, latch the address and pick the response delay
        GRANT: begin
          if (delay_q == 2'd0) begin
            instr_gnt_o <= 1'b1;
            addr_q      <= instr_addr_i;
            delay_q     <= 2'($unsigned($random(seed)) % 4);
            state_q     <= RESPOND;
          end else begin
            delay_q <= delay_q - 2'd1;
          end
        end
        RESPOND: begin
          if (delay_q == 2'd0) begin
            instr_rvalid_o <= 1'b1;
            instr_rdata_o  <= addr_q ^ DATA_MASK;
            // bus error window
            instr_err_o    <= (addr_q >= ERR_LO) && (addr_q <= ERR_HI);
            state_q        <= IDLE;
          end else begin
            delay_q <= delay_q - 2'd1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: hdl/ifu_top.sv
// instruction fetch stage top level
// pc selection, bus fetch unit, if-id register and pc check

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic [`IFU_ADDR_W-1:0]  boot_addr_i,
  input  logic                    req_i,
  input  ifu_ctrl_pkg::pc_ctrl_t  pc_ctrl_i,
  input  logic [`IFU_ADDR_W-1:0]  jump_target_i,
  input  ifu_ctrl_pkg::csr_pc_t   csr_i,
  input  logic                    id_in_ready_i,
  input  logic                    instr_valid_clear_i,

  // instruction bus
  output logic                    instr_req_o,
  output logic [`IFU_ADDR_W-1:0]  instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`IFU_ADDR_W-1:0]  instr_rdata_i,
  input  logic                    instr_err_i,

  // decode side
  output ifu_bus_pkg::if_id_t     if_id_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic [`IFU_ADDR_W-1:0]  pc_if_o,
  output logic                    csr_mtvec_init_o,
  output logic                    pc_mismatch_alert_o,
  output logic                    if_busy_o
);
  import ifu_bus_pkg::*;

  logic [`IFU_ADDR_W-1:0] fetch_addr_n;
  logic                   fetch_valid;
  fetch_rsp_t             fetch_rsp;
  logic                   accept;

  ifu_pc_select u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .pc_ctrl_i        (pc_ctrl_i),
    .csr_i            (csr_i),
    .fetch_addr_o     (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ifu_fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_ctrl_i.pc_set),
    .fetch_addr_i   (fetch_addr_n),
    .id_in_ready_i  (id_in_ready_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_rsp_o    (fetch_rsp),
    .busy_o         (if_busy_o)
  );

  ifu_id_pipe u_id_pipe (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rsp_i         (fetch_rsp),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_ctrl_i.pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .if_id_o             (if_id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .accept_o            (accept)
  );

  // pc of the word waiting in the fetch buffer
  assign pc_if_o = fetch_rsp.addr;

  ifu_pc_check u_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .accept_i            (accept),
    .pc_set_i            (pc_ctrl_i.pc_set),
    .fetch_valid_i       (fetch_valid),
    .pc_if_i             (pc_if_o),
    .pc_id_i             (if_id_o.pc),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// File: hdl/ifu_pc_check.sv
// sequential pc hardening check
// flags a fetched pc that does not follow the last accepted one

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_pc_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   accept_i,
  input  logic                   pc_set_i,
  input  logic                   fetch_valid_i,
  input  logic [`IFU_ADDR_W-1:0] pc_if_i,
  input  logic [`IFU_ADDR_W-1:0] pc_id_i,
  output logic                   pc_mismatch_alert_o
);

  logic                   seq_d;
  logic                   seq_q;
  logic [`IFU_ADDR_W-1:0] pc_expected;

  // armed by an accepted word, any redirect breaks the sequence
  assign seq_d = (seq_q | accept_i) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // every instruction is a full word
  assign pc_expected = pc_id_i + `IFU_ADDR_W'(`IFU_INSTR_STEP);

  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (pc_if_i != pc_expected);

endmodule

// File: hdl/ifu_id_pipe.sv
// if-id pipeline register
// loads the fetched word on accept, tracks valid and new flags

`timescale 1ns/100ps

module ifu_id_pipe (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_valid_i,
  input  ifu_bus_pkg::fetch_rsp_t fetch_rsp_i,
  input  logic                    id_in_ready_i,
  input  logic                    pc_set_i,
  input  logic                    instr_valid_clear_i,
  output ifu_bus_pkg::if_id_t     if_id_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic                    accept_o
);
  import ifu_bus_pkg::*;

  logic   accept;
  logic   valid_d;
  logic   valid_q;
  logic   new_q;
  if_id_t if_id_q;

  // handshake between fetch buffer and decode
  assign accept = fetch_valid_i & id_in_ready_i;

  // a word accepted alongside a redirect is loaded but squashed
  // valid then holds until decode clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // single cycle marker for each word entering decode
      new_q   <= accept;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      if_id_q <= '0;
    end else if (accept) begin
      if_id_q.instr_rdata <= fetch_rsp_i.rdata;
      if_id_q.pc          <= fetch_rsp_i.addr;
      if_id_q.fetch_err   <= fetch_rsp_i.err;
    end
  end

  assign if_id_o          = if_id_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign accept_o         = accept;

endmodule

// File: hdl/ifu_fetch_unit.sv
// instruction bus master for the fetch stage
// one request outstanding at a time, one entry response buffer
// redirects drop the buffer and discard any response in flight

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_fetch_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    pc_set_i,
  input  logic [`IFU_ADDR_W-1:0]  fetch_addr_i,
  input  logic                    id_in_ready_i,
  output logic                    instr_req_o,
  output logic [`IFU_ADDR_W-1:0]  instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`IFU_ADDR_W-1:0]  instr_rdata_i,
  input  logic                    instr_err_i,
  output logic                    fetch_valid_o,
  output ifu_bus_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                    busy_o
);
  import ifu_bus_pkg::*;

  logic                   armed_q;
  logic                   req_q;
  logic                   out_q;
  logic                   kill_q;
  logic                   buf_valid_q;
  logic [`IFU_ADDR_W-1:0] next_addr_q;
  logic [`IFU_ADDR_W-1:0] req_addr_q;
  fetch_rsp_t             buf_q;

  logic                   consume;
  logic                   launch;
  logic                   rsp_end;
  logic                   rsp_live;
  logic [`IFU_ADDR_W-1:0] redirect_addr;
  logic [`IFU_ADDR_W-1:0] launch_addr;

  ////////////////////
  // request control
  ////////////////////

  assign redirect_addr = {fetch_addr_i[`IFU_ADDR_W-1:2], 2'b00};
  assign consume       = buf_valid_q & id_in_ready_i;
  assign rsp_end       = instr_rvalid_i & out_q;
  // a response is kept unless it belongs to an abandoned stream
  assign rsp_live      = rsp_end & ~kill_q & ~pc_set_i;

  // new request when the bus is idle and the buffer will be free next cycle
  // nothing is fetched before the first redirect loads an address
  assign launch      = req_i & (armed_q | pc_set_i) & ~req_q & ~out_q &
                       (pc_set_i | ~buf_valid_q | consume);
  assign launch_addr = pc_set_i ? redirect_addr : next_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q     <= 1'b0;
      req_q       <= 1'b0;
      out_q       <= 1'b0;
      kill_q      <= 1'b0;
      req_addr_q  <= '0;
      next_addr_q <= '0;
    end else begin
      armed_q <= armed_q | pc_set_i;
      // request held with a stable address until granted
      if (launch) begin
        req_q      <= 1'b1;
        req_addr_q <= launch_addr;
      end else if (req_q && instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && instr_gnt_i) begin
        out_q <= 1'b1;
      end else if (rsp_end) begin
        out_q <= 1'b0;
      end
      // redirect while a transaction is in flight, drop its response
      kill_q <= (kill_q | (pc_set_i & (req_q | out_q))) & ~rsp_end;
      if (launch) begin
        next_addr_q <= launch_addr + `IFU_ADDR_W'(`IFU_INSTR_STEP);
      end else if (pc_set_i) begin
        next_addr_q <= redirect_addr;
      end
    end
  end

  ////////////////////
  // response buffer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
      buf_q       <= '0;
    end else begin
      if (pc_set_i) begin
        buf_valid_q <= 1'b0;
      end else if (rsp_live) begin
        buf_valid_q <= 1'b1;
      end else if (consume) begin
        buf_valid_q <= 1'b0;
      end
      // tag the word with the address of its request
      if (rsp_live) begin
        buf_q.rdata <= instr_rdata_i;
        buf_q.addr  <= req_addr_q;
        buf_q.err   <= instr_err_i;
      end
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = req_addr_q;
  assign fetch_valid_o = buf_valid_q;
  assign fetch_rsp_o   = buf_q;
  assign busy_o        = req_q | out_q;

endmodule

// File: hdl/ifu_pc_select.sv
// next pc selection for the fetch stage
// exception pc mux, fetch address mux and mtvec init strobe

`timescale 1ns/100ps

`include "ifu_cfg.svh"

module ifu_pc_select (
  input  logic [`IFU_ADDR_W-1:0] boot_addr_i,
  input  logic [`IFU_ADDR_W-1:0] jump_target_i,
  input  ifu_ctrl_pkg::pc_ctrl_t pc_ctrl_i,
  input  ifu_ctrl_pkg::csr_pc_t  csr_i,
  output logic [`IFU_ADDR_W-1:0] fetch_addr_o,
  output logic                   csr_mtvec_init_o
);
  import ifu_ctrl_pkg::*;

  logic [`IFU_ADDR_W-1:0] boot_pc;
  logic [`IFU_ADDR_W-1:0] exc_pc;
  logic [`IFU_ADDR_W-1:0] next_pc;

  // boot pc sits at a fixed offset in the 256 byte boot region
  assign boot_pc = {boot_addr_i[`IFU_ADDR_W-1:8], `IFU_BOOT_OFFSET};

  // handler entry, irq vectors are one word apart above mtvec base
  always_comb begin
    unique case (pc_ctrl_i.exc_pc_mux)
      EXC_PC_EXC:     exc_pc = {csr_i.mtvec[`IFU_ADDR_W-1:8], 8'h00};
      EXC_PC_IRQ:     exc_pc = {csr_i.mtvec[`IFU_ADDR_W-1:8], 1'b0,
                                pc_ctrl_i.exc_cause[4:0], 2'b00};
      EXC_PC_DBD:     exc_pc = `IFU_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IFU_DM_EXC_ADDR;
      default:        exc_pc = {csr_i.mtvec[`IFU_ADDR_W-1:8], 8'h00};
    endcase
  end

  // fetch address source
  always_comb begin
    unique case (pc_ctrl_i.pc_mux)
      PC_BOOT: next_pc = boot_pc;
      PC_JUMP: next_pc = jump_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap handler
      PC_ERET: next_pc = csr_i.mepc;
      // return from debug mode
      PC_DRET: next_pc = csr_i.depc;
      default: next_pc = boot_pc;
    endcase
  end

  // halfword alignment at least, fetch unit clears bit 1
  assign fetch_addr_o = {next_pc[`IFU_ADDR_W-1:1], 1'b0};

  // csr file loads its mtvec reset value on the boot redirect
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_mux == PC_BOOT);

endmodule

// File: hdl/ifu_bus_pkg.sv
// payload types of the fetch datapath
// one fetched bus response and the if-id stage contents

`include "ifu_cfg.svh"

package ifu_bus_pkg;

  // response word tagged with the address it was fetched from
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] rdata;
    logic [`IFU_ADDR_W-1:0] addr;
    logic                   err;
  } fetch_rsp_t;

  // contents of the if-id register handed to decode
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] instr_rdata;
    logic [`IFU_ADDR_W-1:0] pc;
    // bus error on the fetch of this word
    logic                   fetch_err;
  } if_id_t;

endpackage

// File: hdl/ifu_ctrl_pkg.sv
// control types seen by the fetch stage
// pc source and handler selects, redirect request and csr pc values

`include "ifu_cfg.svh"

package ifu_ctrl_pkg;

  // source of the next fetch pc
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // handler entry used when pc_mux selects an exception pc
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // one redirect from the controller
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    // bit 5 marks an interrupt, bits 4:0 hold the vector
    logic [5:0]  exc_cause;
  } pc_ctrl_t;

  // pc related csr values
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] mepc;
    logic [`IFU_ADDR_W-1:0] depc;
    logic [`IFU_ADDR_W-1:0] mtvec;
  } csr_pc_t;

endpackage

// File: include/ifu_cfg.svh
// fetch stage configuration constants
// boot offset, debug entry points, datapath width and pc step
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// address and instruction width
`define IFU_ADDR_W 32

// low byte of the boot pc, placed under boot_addr[31:8]
`define IFU_BOOT_OFFSET 8'h80

// debug module entry points
`define IFU_DM_HALT_ADDR 32'h1A110800
`define IFU_DM_EXC_ADDR 32'h1A110808

// byte step between sequential instructions, no compressed ones
`define IFU_INSTR_STEP 4

`endif
